/* src/rv_pkg.sv */
package rv_pkg;

    // ========================================================================
    // widths and constants
    // ========================================================================
    localparam int xlen       = 32;              // data and address width
    localparam int reg_addr_w = 5;               // register index width

    localparam logic [xlen-1:0] reset_pc  = 32'h0000_0000;  // first fetch address
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;  // addi x0,x0,0

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_system = 7'b1110011     // ecall / ebreak, both halt
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b                  // lui, result is the immediate
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge
    } br_op_e;

    // source of the register write value
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_e;

    // ========================================================================
    // control word carried from decode down to writeback
    // ========================================================================
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;           // operand b from imm
        logic    use_pc;            // operand a from pc (auipc)
        br_op_e  br_op;
        logic    jump;              // jal or jalr
        logic    jalr;              // target from alu sum
        logic    mem_we;
        wb_sel_e wb_sel;
        logic    rf_we;
        logic    halt;
    } ctrl_t;

    // bubble inserted on reset and flush, writes nothing
    localparam ctrl_t nop_ctrl = '{
        alu_op:  alu_add,
        use_imm: 1'b0,
        use_pc:  1'b0,
        br_op:   br_none,
        jump:    1'b0,
        jalr:    1'b0,
        mem_we:  1'b0,
        wb_sel:  wb_alu,
        rf_we:   1'b0,
        halt:    1'b0
    };

endpackage

/* src/rv_stage_if.sv */
`timescale 1ns/1ps

// IF/ID contents
interface fd_if;
    logic [rv_pkg::xlen-1:0] instr;
    logic [rv_pkg::xlen-1:0] pc;

    modport source (output instr, pc);
    modport sink   (input  instr, pc);
endinterface

// ID/EX contents, plus the redirect back from execute
interface de_if;
    rv_pkg::ctrl_t                 ctrl;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       rs1_data;
    logic [rv_pkg::xlen-1:0]       rs2_data;
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::xlen-1:0]       pc;
    logic                          redirect;   // taken branch or jump, also the flush
    logic [rv_pkg::xlen-1:0]       target;

    modport source (output ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm, pc, input redirect);
    modport sink   (input ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm, pc,
                    output redirect, target);
    modport redir  (input redirect, target);   // fetch only needs the redirect
endinterface

// EX/MEM contents, fwd_value comes back for the first forwarding level
interface em_if;
    rv_pkg::ctrl_t                 ctrl;
    logic [rv_pkg::xlen-1:0]       alu_result;
    logic [rv_pkg::xlen-1:0]       store_data;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       pc4;
    logic [rv_pkg::xlen-1:0]       fwd_value;

    modport source (output ctrl, alu_result, store_data, rd, pc4, input fwd_value);
    modport sink   (input ctrl, alu_result, store_data, rd, pc4, output fwd_value);
endinterface

// MEM/WB outputs, the register file write port
interface wb_if;
    logic                          rf_we;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       wb_data;

    modport source (output rf_we, rd, wb_data);
    modport sink   (input  rf_we, rd, wb_data);
endinterface

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic [rv_pkg::xlen-1:0]       wd
);

    logic [rv_pkg::xlen-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;                 // writes to x0 dropped
        end
    end

    // two combinational read ports
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    fd_if.source                    fd,
    de_if.redir                     de,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_rdata
);

    logic [rv_pkg::xlen-1:0] pc;        // address being fetched this cycle
    logic [rv_pkg::xlen-1:0] pc_next;

    assign imem_addr = pc;              // combinational instruction read

    // taken branch or jump from execute wins over sequential fetch
    assign pc_next = de.redirect ? de.target : pc + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= rv_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // ========================================================================
    // IF/ID register
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd.instr <= rv_pkg::nop_instr;  // decode starts on a nop
            fd.pc    <= rv_pkg::reset_pc;
        end else begin
            fd.instr <= de.redirect ? rv_pkg::nop_instr : imem_rdata;   // squash wrong path
            fd.pc    <= pc;
        end
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic clk,
    input  logic arst_n,
    fd_if.sink   fd,
    de_if.source de,
    wb_if.sink   wb
);

    rv_pkg::opcode_e               opcode;
    rv_pkg::ctrl_t                 ctrl;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [2:0]                    funct3;
    logic                          alt;        // funct7 bit 5, sub / sra
    logic [rv_pkg::xlen-1:0]       imm;
    logic [rv_pkg::xlen-1:0]       rf_rs1;     // raw register file reads
    logic [rv_pkg::xlen-1:0]       rf_rs2;
    logic [rv_pkg::xlen-1:0]       rs1_byp;    // after writeback bypass
    logic [rv_pkg::xlen-1:0]       rs2_byp;

    assign opcode = rv_pkg::opcode_e'(fd.instr[6:0]);
    assign rd     = fd.instr[11:7];
    assign funct3 = fd.instr[14:12];
    assign rs1    = fd.instr[19:15];
    assign rs2    = fd.instr[24:20];
    assign alt    = fd.instr[30];

    // funct3 to alu op, shared by op and op_imm
    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra,
                                                input logic is_reg);
        case (f3)
            3'b000:  alu_sel = (sub_sra && is_reg) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  alu_sel = rv_pkg::alu_sll;
            3'b010:  alu_sel = rv_pkg::alu_slt;
            3'b011:  alu_sel = rv_pkg::alu_sltu;
            3'b100:  alu_sel = rv_pkg::alu_xor;
            3'b101:  alu_sel = sub_sra ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  alu_sel = rv_pkg::alu_or;
            default: alu_sel = rv_pkg::alu_and;
        endcase
    endfunction

    // ========================================================================
    // decoder and immediates
    // ========================================================================
    always_comb begin
        ctrl = rv_pkg::nop_ctrl;                                  // unknown opcodes do nothing
        imm  = {{20{fd.instr[31]}}, fd.instr[31:20]};             // I type
        case (opcode)
            rv_pkg::opc_op: begin
                ctrl.alu_op = alu_sel(funct3, alt, 1'b1);
                ctrl.rf_we  = 1'b1;
            end
            rv_pkg::opc_op_imm: begin
                ctrl.alu_op  = alu_sel(funct3, alt, 1'b0);
                ctrl.use_imm = 1'b1;
                ctrl.rf_we   = 1'b1;
            end
            rv_pkg::opc_lui, rv_pkg::opc_auipc: begin
                imm          = {fd.instr[31:12], 12'b0};          // U type
                ctrl.alu_op  = (opcode == rv_pkg::opc_lui) ? rv_pkg::alu_pass_b : rv_pkg::alu_add;
                ctrl.use_pc  = (opcode == rv_pkg::opc_auipc);
                ctrl.use_imm = 1'b1;
                ctrl.rf_we   = 1'b1;
            end
            rv_pkg::opc_jal: begin
                imm = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12], fd.instr[20],
                       fd.instr[30:21], 1'b0};                     // J type
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = rv_pkg::wb_pc4;                      // link = pc+4
                ctrl.rf_we  = 1'b1;
            end
            rv_pkg::opc_jalr: begin
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.use_imm = 1'b1;                               // rs1 + imm on the alu
                ctrl.wb_sel  = rv_pkg::wb_pc4;
                ctrl.rf_we   = 1'b1;
            end
            rv_pkg::opc_branch: begin
                imm = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                       fd.instr[11:8], 1'b0};                      // B type
                case (funct3)
                    3'b000:  ctrl.br_op = rv_pkg::br_beq;
                    3'b001:  ctrl.br_op = rv_pkg::br_bne;
                    3'b100:  ctrl.br_op = rv_pkg::br_blt;
                    3'b101:  ctrl.br_op = rv_pkg::br_bge;
                    default: ctrl.br_op = rv_pkg::br_none;         // unsigned forms not kept
                endcase
            end
            rv_pkg::opc_load: begin
                ctrl.use_imm = 1'b1;
                ctrl.wb_sel  = rv_pkg::wb_mem;
                ctrl.rf_we   = 1'b1;
            end
            rv_pkg::opc_store: begin
                imm          = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};  // S type
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            rv_pkg::opc_system: ctrl.halt = 1'b1;                   // ecall / ebreak
            default: ;
        endcase
    end

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .we       (wb.rf_we),
        .rd       (wb.rd),
        .wd       (wb.wb_data)
    );

    // value written at the end of this cycle is not in the array yet
    assign rs1_byp = (wb.rf_we && (wb.rd != '0) && (wb.rd == rs1)) ? wb.wb_data : rf_rs1;
    assign rs2_byp = (wb.rf_we && (wb.rd != '0) && (wb.rd == rs2)) ? wb.wb_data : rf_rs2;

    // ========================================================================
    // ID/EX register
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de.ctrl <= rv_pkg::nop_ctrl;
        end else begin
            de.ctrl <= de.redirect ? rv_pkg::nop_ctrl : ctrl;   // flush kills the younger one
        end
    end

    always_ff @(posedge clk) begin
        de.rs1      <= rs1;
        de.rs2      <= rs2;
        de.rd       <= rd;
        de.rs1_data <= rs1_byp;
        de.rs2_data <= rs2_byp;
        de.imm      <= imm;
        de.pc       <= fd.pc;
    end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic clk,
    input  logic arst_n,
    de_if.sink   de,
    em_if.source em,
    wb_if.sink   wb
);

    logic [rv_pkg::xlen-1:0] rs1_v;         // operands after forwarding
    logic [rv_pkg::xlen-1:0] rs2_v;
    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] alu_result;
    logic                    eq;
    logic                    lt;            // signed
    logic                    br_taken;

    // memory level first, it holds the younger result
    function automatic logic [rv_pkg::xlen-1:0] fwd(input logic [rv_pkg::reg_addr_w-1:0] rs,
                                                    input logic [rv_pkg::xlen-1:0] rf_val);
        if (em.ctrl.rf_we && (em.rd != '0) && (em.rd == rs)) begin
            fwd = em.fwd_value;
        end else if (wb.rf_we && (wb.rd != '0) && (wb.rd == rs)) begin
            fwd = wb.wb_data;
        end else begin
            fwd = rf_val;
        end
    endfunction

    always_comb begin
        rs1_v = fwd(de.rs1, de.rs1_data);
        rs2_v = fwd(de.rs2, de.rs2_data);
    end

    assign op_a = de.ctrl.use_pc  ? de.pc  : rs1_v;    // auipc
    assign op_b = de.ctrl.use_imm ? de.imm : rs2_v;

    // ========================================================================
    // ALU
    // ========================================================================
    always_comb begin
        case (de.ctrl.alu_op)
            rv_pkg::alu_add:    alu_result = op_a + op_b;
            rv_pkg::alu_sub:    alu_result = op_a - op_b;
            rv_pkg::alu_and:    alu_result = op_a & op_b;
            rv_pkg::alu_or:     alu_result = op_a | op_b;
            rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_pkg::alu_sll:    alu_result = op_a << op_b[4:0];
            rv_pkg::alu_srl:    alu_result = op_a >> op_b[4:0];
            rv_pkg::alu_sra:    alu_result = $signed(op_a) >>> op_b[4:0];
            rv_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_result = {31'b0, op_a < op_b};
            rv_pkg::alu_pass_b: alu_result = op_b;      // lui
            default:            alu_result = '0;
        endcase
    end

    // branch compare always on the register operands
    assign eq = (rs1_v == rs2_v);
    assign lt = ($signed(rs1_v) < $signed(rs2_v));

    always_comb begin
        case (de.ctrl.br_op)
            rv_pkg::br_beq: br_taken = eq;
            rv_pkg::br_bne: br_taken = !eq;
            rv_pkg::br_blt: br_taken = lt;
            rv_pkg::br_bge: br_taken = !lt;
            default:        br_taken = 1'b0;
        endcase
    end

    assign de.redirect = br_taken || de.ctrl.jump;
    // jalr clears bit 0 of rs1+imm, branches and jal are pc relative
    assign de.target   = de.ctrl.jalr ? {alu_result[31:1], 1'b0} : de.pc + de.imm;

    // ========================================================================
    // EX/MEM register
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em.ctrl <= rv_pkg::nop_ctrl;
        end else begin
            em.ctrl <= de.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        em.alu_result <= alu_result;
        em.store_data <= rs2_v;             // forwarded store value
        em.rd         <= de.rd;
        em.pc4        <= de.pc + 32'd4;     // link value
    end

endmodule

/* src/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    em_if.sink                      em,
    wb_if.source                    wb,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_we,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic                    halt
);

    logic [rv_pkg::xlen-1:0] result;    // stage result by wb_sel

    // word access only, memory writes at the next edge
    assign dmem_addr  = em.alu_result;
    assign dmem_wdata = em.store_data;
    assign dmem_we    = em.ctrl.mem_we;

    always_comb begin
        case (em.ctrl.wb_sel)
            rv_pkg::wb_mem: result = dmem_rdata;    // combinational load data
            rv_pkg::wb_pc4: result = em.pc4;
            default:        result = em.alu_result;
        endcase
    end

    assign em.fwd_value = result;       // memory-to-execute forward

    // ========================================================================
    // MEM/WB register
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.rf_we <= 1'b0;
            halt     <= 1'b0;
        end else begin
            wb.rf_we <= em.ctrl.rf_we;
            halt     <= em.ctrl.halt;   // high during the writeback cycle
        end
    end

    always_ff @(posedge clk) begin
        wb.rd      <= em.rd;
        wb.wb_data <= result;
    end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0] imem_rdata,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_we,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output logic                    halt
);

    // stage to stage buses
    fd_if fd_bus ();
    de_if de_bus ();    // also carries the redirect back
    em_if em_bus ();
    wb_if wb_bus ();

    fetch_stage fetch_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .fd         (fd_bus.source),
        .de         (de_bus.redir),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata)
    );

    decode_stage decode_i (
        .clk    (clk),
        .arst_n (arst_n),
        .fd     (fd_bus.sink),
        .de     (de_bus.source),
        .wb     (wb_bus.sink)       // register write and bypass
    );

    execute_stage execute_i (
        .clk    (clk),
        .arst_n (arst_n),
        .de     (de_bus.sink),
        .em     (em_bus.source),
        .wb     (wb_bus.sink)       // second forwarding level
    );

    memory_stage memory_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .em         (em_bus.sink),
        .wb         (wb_bus.source),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

endmodule

/* verif/rv_core_asserts.sv */
`timescale 1ns/1ps

module rv_core_asserts #(
    parameter logic [rv_pkg::xlen-1:0] poison_addr = 32'hffff_fffc
) (
    input logic                    clk,
    input logic                    arst_n,
    input logic [rv_pkg::xlen-1:0] imem_addr,
    input logic [rv_pkg::xlen-1:0] dmem_addr,
    input logic                    dmem_we,
    input logic                    halt
);

    int fail_count = 0;     // failed assertions so far

    // ========================================================================
    // reset state
    // ========================================================================
    // sampled mid-cycle while reset is held
    reset_hold: assert property (@(negedge clk)
        !arst_n |-> (imem_addr == rv_pkg::reset_pc) && !dmem_we && !halt)
        else begin
            $error("core state wrong while reset is held");
            fail_count++;
        end

    // nop control words from reset drain through memory and writeback
    reset_release: assert property (@(posedge clk)
        $rose(arst_n) |-> ((imem_addr == rv_pkg::reset_pc) && !dmem_we && !halt)
                          ##1 (!dmem_we && !halt) ##1 (!dmem_we && !halt))
        else begin
            $error("core state wrong in the first cycles after reset");
            fail_count++;
        end

    // ========================================================================
    // running
    // ========================================================================
    no_poison_store: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> (dmem_addr != poison_addr))        // squashed stores never reach memory
        else begin
            $error("store from a flushed instruction reached data memory");
            fail_count++;
        end

    no_store_at_halt: assert property (@(posedge clk) disable iff (!arst_n)
        halt |-> !dmem_we)
        else begin
            $error("store in the cycle halt is high");
            fail_count++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            fail_count++;
        end

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int          max_cycles  = 200;              // about 4x the program length
    localparam logic [31:0] poison_addr = 32'h0000_03f0;    // wrong-path stores aim here
    localparam logic [6:0]  opc_imm     = 7'b0010011;
    localparam logic [6:0]  opc_load    = 7'b0000011;
    localparam logic [6:0]  opc_jalr    = 7'b1100111;
    localparam logic [6:0]  opc_lui     = 7'b0110111;
    localparam logic [6:0]  opc_auipc   = 7'b0010111;
    localparam logic [31:0] ecall       = 32'h0000_0073;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;
    logic        halt;

    logic [31:0] prog [0:63];           // instruction memory
    logic [31:0] dmem [0:255];          // data memory indexed by word
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_test [$];
    int          store_idx  = 0;
    int          mismatches = 0;
    int          extra      = 0;
    int          missing    = 0;
    int          cycles     = 0;
    bit          timed_out  = 1'b0;

    always #10 clk = ~clk;              // 20 ns period

    rv_core dut_i (.*);

    bind rv_core rv_core_asserts #(.poison_addr(32'h0000_03f0)) asserts_i (.*);

    // both memories answer combinationally
    assign imem_rdata = prog[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;     // write lands on the rising edge
        end
    end

    // ========================================================================
    // instruction encoders following the RV32I field layout
    // ========================================================================
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        i_type = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        s_type = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw only
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        u_type = {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic expect_store(input string test, input logic [31:0] addr,
                                input logic [31:0] data);
        exp_test.push_back(test);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // ========================================================================
    // program image with x10 as the store base 0x100
    // ========================================================================
    task automatic fill_program();
        logic [31:0] poison_sw;
        poison_sw = s_type(12'h0, 21, 21);                      // sw x21,0(x21)
        for (int i = 0; i < 64; i++) begin
            prog[i] = i_type(i[11:0], 0, 3'b000, 0, opc_imm);   // addi x0,x0,i
        end
        prog[0]  = i_type(12'h100, 0, 3'b000, 10, opc_imm);    // x10 = 0x100
        prog[1]  = i_type(12'hfec, 0, 3'b000, 1, opc_imm);     // x1 = -20
        prog[2]  = i_type(12'h003, 0, 3'b000, 2, opc_imm);     // x2 = 3
        prog[3]  = r_type(7'h00, 2, 1, 3'b000, 3);             // add through mem and wb forward
        prog[4]  = r_type(7'h20, 2, 3, 3'b101, 4);             // sra
        prog[5]  = r_type(7'h20, 1, 2, 3'b000, 6);             // sub reads x2 via decode bypass
        prog[6]  = r_type(7'h00, 2, 4, 3'b010, 5);             // slt on a negative value
        prog[7]  = r_type(7'h00, 3, 6, 3'b100, 7);             // xor
        prog[8]  = s_type(12'd0, 3, 10);
        prog[9]  = s_type(12'd4, 4, 10);
        prog[10] = s_type(12'd8, 5, 10);
        prog[11] = s_type(12'd12, 7, 10);
        prog[12] = u_type(20'h12345, 8, opc_lui);
        prog[13] = i_type(12'h678, 8, 3'b110, 9, opc_imm);     // ori
        prog[14] = i_type(12'h004, 9, 3'b101, 11, opc_imm);    // srli
        prog[15] = i_type(12'h005, 2, 3'b001, 12, opc_imm);    // slli
        prog[16] = i_type(12'h0ff, 9, 3'b111, 13, opc_imm);    // andi
        prog[17] = r_type(7'h00, 1, 2, 3'b011, 14);            // sltu
        prog[18] = u_type(20'h00001, 15, opc_auipc);           // pc 0x48
        prog[19] = i_type(12'd55, 0, 3'b000, 0, opc_imm);      // write to x0
        prog[20] = s_type(12'd16, 0, 10);                      // must store zero
        prog[21] = s_type(12'd20, 9, 10);
        prog[22] = s_type(12'd24, 11, 10);
        prog[23] = s_type(12'd28, 12, 10);
        prog[24] = s_type(12'd32, 13, 10);
        prog[25] = s_type(12'd36, 14, 10);
        prog[26] = s_type(12'd40, 15, 10);
        prog[27] = i_type(poison_addr[11:0], 0, 3'b000, 21, opc_imm);
        prog[28] = b_type(13'd12, 2, 2, 3'b000);               // beq taken to 31
        prog[29] = poison_sw;
        prog[30] = ecall;                                      // flushed so it never halts
        prog[31] = b_type(13'd12, 2, 1, 3'b100);               // blt taken to 34
        prog[32] = poison_sw;
        prog[33] = poison_sw;
        prog[34] = b_type(13'd8, 2, 2, 3'b001);                // bne not taken
        prog[35] = s_type(12'd44, 2, 10);
        prog[36] = j_type(21'd12, 22);                         // jal to 39
        prog[37] = poison_sw;
        prog[38] = poison_sw;
        prog[39] = s_type(12'd48, 22, 10);
        prog[40] = i_type(12'd175, 0, 3'b000, 23, opc_imm);
        prog[41] = i_type(12'd2, 23, 3'b000, 24, opc_jalr);    // 177 with bit 0 cleared
        prog[42] = poison_sw;
        prog[43] = poison_sw;
        prog[44] = s_type(12'd52, 24, 10);
        prog[45] = i_type(12'd4, 10, 3'b010, 25, opc_load);    // lw the sra result
        prog[46] = i_type(12'd1, 25, 3'b000, 26, opc_imm);     // used right away
        prog[47] = s_type(12'd56, 26, 10);
        prog[48] = ecall;
    endtask

    // expected values worked out by hand
    task automatic build_store_table();
        expect_store("alu_chain", 32'h100, 32'hffff_ffef);   // -20 + 3
        expect_store("alu_chain", 32'h104, 32'hffff_fffd);   // -17 >>> 3
        expect_store("alu_chain", 32'h108, 32'h0000_0001);   // -3 < 3
        expect_store("alu_chain", 32'h10c, 32'hffff_fff8);   // 23 ^ -17
        expect_store("alu_imm", 32'h110, 32'h0000_0000);     // x0 stays zero
        expect_store("alu_imm", 32'h114, 32'h1234_5678);
        expect_store("alu_imm", 32'h118, 32'h0123_4567);
        expect_store("alu_imm", 32'h11c, 32'h0000_0060);
        expect_store("alu_imm", 32'h120, 32'h0000_0078);
        expect_store("alu_imm", 32'h124, 32'h0000_0001);     // 3 < 0xffffffec unsigned
        expect_store("alu_imm", 32'h128, 32'h0000_1048);     // auipc
        expect_store("branch", 32'h12c, 32'h0000_0003);      // bne fall through
        expect_store("jal", 32'h130, 32'h0000_0094);         // link 0x90 + 4
        expect_store("jalr", 32'h134, 32'h0000_00a8);        // link 0xa4 + 4
        expect_store("load_use", 32'h138, 32'hffff_fffe);
    endtask

    // ========================================================================
    // store checker in program order
    // ========================================================================
    always @(negedge clk) begin
        if (arst_n && dmem_we) begin
            assert (store_idx < exp_addr.size()) else begin
                extra++;
                $display("store to %h of %h was not expected", dmem_addr, dmem_wdata);
            end
            if (store_idx < exp_addr.size()) begin
                assert ({dmem_addr, dmem_wdata} == {exp_addr[store_idx], exp_data[store_idx]})
                else begin
                    mismatches++;
                    $display("mismatch %s: expected %h <= %h, actual %h <= %h",
                             exp_test[store_idx], exp_addr[store_idx], exp_data[store_idx],
                             dmem_addr, dmem_wdata);
                end
            end
            store_idx++;
        end
    end

    initial begin
        int total;
        arst_n = 1'b0;
        void'($urandom(32'h077ef5cc));      // one seed for the whole run
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $urandom;             // unused words hold noise
        end
        fill_program();
        build_store_table();
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        while (halt !== 1'b1 && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (halt !== 1'b1) begin
            timed_out = 1'b1;
            $display("timeout: halt did not rise within %0d cycles", max_cycles);
        end
        @(posedge clk);                     // halt cycle ends here
        @(negedge clk);
        if (store_idx < exp_addr.size()) begin
            missing = exp_addr.size() - store_idx;
            $display("only %0d of %0d expected stores were seen", store_idx, exp_addr.size());
        end
        total = mismatches + extra + missing + dut_i.asserts_i.fail_count + int'(timed_out);
        $display("errors: mismatch %0d, extra %0d, missing %0d, assertion %0d, timeout %0d",
                 mismatches, extra, missing, dut_i.asserts_i.fail_count, timed_out);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
src/rv_pkg.sv
src/rv_stage_if.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
verif/rv_core_asserts.sv
verif/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/rv_stage_if.sv
  - src/reg_file.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/rv_core.sv
  - target: test
    files:
      - verif/rv_core_asserts.sv
      - verif/rv_core_tb.sv
